// File: include/rvviBridge_settings.svh
// Widths, counts, CSR slot indices, APB register map and reset values of the trace bridge
`ifndef RVVI_BRIDGE_SETTINGS_SVH
`define RVVI_BRIDGE_SETTINGS_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////
`define RVVI_XLEN       32
`define RVVI_ORDER_W    64
`define RVVI_MODE_W     2
`define RVVI_IXL_W      2

// Counts
`define RVVI_NUM_CSR    8
`define RVVI_NUM_GPR    32
`define RVVI_NUM_IRQ    32
// Irq lines first, halt request on top
`define RVVI_NUM_NETS   33
`define RVVI_NET_HALT   32

//////////////////////////////////////////////////
// Tracked CSR slots
//////////////////////////////////////////////////
`define RVVI_CSR_MSTATUS   0
`define RVVI_CSR_MIE       1
`define RVVI_CSR_MTVEC     2
`define RVVI_CSR_MSCRATCH  3
`define RVVI_CSR_MEPC      4
`define RVVI_CSR_MCAUSE    5
`define RVVI_CSR_MIP       6
`define RVVI_CSR_DPC       7

//////////////////////////////////////////////////
// APB register map
//////////////////////////////////////////////////
`define RVVI_APB_AW        4
`define RVVI_REG_CTRL      4'h0
`define RVVI_REG_CSRCMP    4'h4
`define RVVI_REG_IRQMASK   4'h8
`define RVVI_REG_RETCNT    4'hC

// Reset values
`define RVVI_ENABLE_RST    1'b0
`define RVVI_CSRCMP_RST    8'hFF
// MSI, MTI, MEI and the 16 local lines
`define RVVI_IRQMASK_RST   32'hFFFF0888

`endif

// File: rtl/rvviBridgePkg.sv
// Shared vector typedefs and the net output state enum of the trace bridge
`default_nettype none

`include "rvviBridge_settings.svh"

package rvviBridgePkg;

    //////////////////////////////////////////////////
    // Data and register file
    //////////////////////////////////////////////////

    // One architectural data word
    typedef logic [`RVVI_XLEN-1:0] xlenT;

    // GPR index, x0 to x31
    typedef logic [$clog2(`RVVI_NUM_GPR)-1:0] gprAddrT;

    // One bit per GPR written back
    typedef logic [`RVVI_NUM_GPR-1:0] gprVecT;

    //////////////////////////////////////////////////
    // CSR slots
    //////////////////////////////////////////////////

    // Per slot flag or enable
    typedef logic [`RVVI_NUM_CSR-1:0] csrVecT;

    // All tracked CSRs side by side, slot 0 in the low word
    typedef xlenT [`RVVI_NUM_CSR-1:0] csrBusT;

    //////////////////////////////////////////////////
    // Nets
    //////////////////////////////////////////////////

    // Wide enough for irq lines plus halt request
    typedef logic [$clog2(`RVVI_NUM_NETS)-1:0] netIdxT;

    // Raw core interrupt lines
    typedef logic [`RVVI_NUM_IRQ-1:0] irqVecT;

    // Output side of the event queue
    typedef enum logic {
        netIdle,
        netOffer
    } netStateT;

endpackage

`default_nettype wire

// File: rtl/rvviApbRegs.sv
// APB register block: bridge enable, CSR compare enables, irq watch mask, retirement counter
`default_nettype none

`include "rvviBridge_settings.svh"

module rvviApbRegs import rvviBridgePkg::*; (
    input  wire logic                    rvvi_i,
    input  wire logic                    rstN_i,
    // APB slave
    input  wire logic [`RVVI_APB_AW-1:0] paddr_i,
    input  wire logic                    psel_i,
    input  wire logic                    penable_i,
    input  wire logic                    pwrite_i,
    input  wire xlenT                    pwdata_i,
    output      xlenT                    prdata_o,
    output      logic                    pready_o,
    // From retirement stage
    input  wire logic                    retireFire_i,
    // Control out to datapath
    output      logic                    enable_o,
    output      csrVecT                  csrCmpEn_o,
    output      irqVecT                  irqMask_o
);

    logic   wrEn;
    logic   enableQ;
    csrVecT csrCmpEnQ;
    irqVecT irqMaskQ;
    xlenT   retCntQ;

    //////////////////////////////////////////////////
    // Bus decode
    //////////////////////////////////////////////////

    // No wait states, setup plus one access cycle
    assign pready_o = 1'b1;

    // Write lands on the access edge
    assign wrEn = psel_i & penable_i & pwrite_i;

    //////////////////////////////////////////////////
    // Writable registers
    //////////////////////////////////////////////////
    always_ff @(posedge rvvi_i or negedge rstN_i) begin
        if (!rstN_i) begin
            enableQ   <= `RVVI_ENABLE_RST;
            csrCmpEnQ <= `RVVI_CSRCMP_RST;
            irqMaskQ  <= `RVVI_IRQMASK_RST;
        end else if (wrEn) begin
            case (paddr_i)
                `RVVI_REG_CTRL: begin
                    enableQ <= pwdata_i[0];
                end
                `RVVI_REG_CSRCMP: begin
                    csrCmpEnQ <= pwdata_i[`RVVI_NUM_CSR-1:0];
                end
                `RVVI_REG_IRQMASK: begin
                    irqMaskQ <= pwdata_i[`RVVI_NUM_IRQ-1:0];
                end
                // RETCNT and holes ignore writes
                default: begin
                end
            endcase
        end
    end

    // Retirement counter, free running with wrap
    always_ff @(posedge rvvi_i or negedge rstN_i) begin
        if (!rstN_i) begin
            retCntQ <= '0;
        end else if (retireFire_i) begin
            retCntQ <= retCntQ + xlenT'(1);
        end
    end

    //////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////

    // Valid through the access phase, holes read zero
    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            `RVVI_REG_CTRL:    prdata_o = xlenT'(enableQ);
            `RVVI_REG_CSRCMP:  prdata_o = xlenT'(csrCmpEnQ);
            `RVVI_REG_IRQMASK: prdata_o = xlenT'(irqMaskQ);
            `RVVI_REG_RETCNT:  prdata_o = retCntQ;
            default:           prdata_o = '0;
        endcase
    end

    // Control out
    assign enable_o   = enableQ;
    assign csrCmpEn_o = csrCmpEnQ;
    assign irqMask_o  = irqMaskQ;

endmodule

`default_nettype wire

// File: rtl/rvviRetireStage.sv
// Registered pass-through of RVFI retirement fields and the GPR writeback vector
`default_nettype none

`include "rvviBridge_settings.svh"

module rvviRetireStage import rvviBridgePkg::*; (
    input  wire logic                    rvvi_i,
    input  wire logic                    rstN_i,
    input  wire logic                    enable_i,
    // RVFI retirement port
    input  wire logic                    rvfiValid_i,
    input  wire logic [`RVVI_ORDER_W-1:0] rvfiOrder_i,
    input  wire xlenT                    rvfiInsn_i,
    input  wire xlenT                    rvfiPc_i,
    input  wire logic                    rvfiTrap_i,
    input  wire logic                    rvfiIntr_i,
    input  wire logic [`RVVI_MODE_W-1:0] rvfiMode_i,
    input  wire logic [`RVVI_IXL_W-1:0]  rvfiIxl_i,
    input  wire gprAddrT                 rdAddr0_i,
    input  wire gprAddrT                 rdAddr1_i,
    input  wire xlenT                    rdWdata0_i,
    input  wire xlenT                    rdWdata1_i,
    // Accepted retirement, same cycle
    output      logic                    retireFire_o,
    // RVVI trace side, one cycle later
    output      logic                    valid_o,
    output      logic [`RVVI_ORDER_W-1:0] order_o,
    output      xlenT                    insn_o,
    output      xlenT                    pc_o,
    output      logic                    trap_o,
    output      logic                    intr_o,
    output      logic [`RVVI_MODE_W-1:0] mode_o,
    output      logic [`RVVI_IXL_W-1:0]  ixl_o,
    output      gprVecT                  xWb_o,
    output      xlenT                    xWdata0_o,
    output      xlenT                    xWdata1_o
);

    logic   fire;
    gprVecT wbVec;
    xlenT   wdata0Fwd;

    // Retirement only counts while the bridge is on
    assign fire         = enable_i & rvfiValid_i;
    assign retireFire_o = fire;

    //////////////////////////////////////////////////
    // Writeback vector
    //////////////////////////////////////////////////
    always_comb begin
        wbVec = '0;
        // x0 is hardwired, never flagged
        if (rdAddr0_i != '0) begin
            wbVec[rdAddr0_i] = 1'b1;
        end
        if (rdAddr1_i != '0) begin
            wbVec[rdAddr1_i] = 1'b1;
        end
    end

    // Same target on both ports, port 1 wins
    assign wdata0Fwd = (rdAddr0_i == rdAddr1_i) ? rdWdata1_i : rdWdata0_i;

    // Strobes, cleared when nothing retires
    always_ff @(posedge rvvi_i or negedge rstN_i) begin
        if (!rstN_i) begin
            valid_o <= 1'b0;
            xWb_o   <= '0;
        end else begin
            valid_o <= fire;
            xWb_o   <= fire ? wbVec : '0;
        end
    end

    // Payload, loaded only on accepted retirement
    always_ff @(posedge rvvi_i) begin
        if (fire) begin
            order_o   <= rvfiOrder_i;
            insn_o    <= rvfiInsn_i;
            pc_o      <= rvfiPc_i;
            trap_o    <= rvfiTrap_i;
            intr_o    <= rvfiIntr_i;
            mode_o    <= rvfiMode_i;
            ixl_o     <= rvfiIxl_i;
            xWdata0_o <= wdata0Fwd;
            xWdata1_o <= rdWdata1_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rvviCsrMerge.sv
// Masked CSR merge, held CSR values and per slot change flags
`default_nettype none

`include "rvviBridge_settings.svh"

module rvviCsrMerge import rvviBridgePkg::*; (
    input  wire logic   rvvi_i,
    input  wire logic   rstN_i,
    // Accepted retirement from retire stage
    input  wire logic   retire_i,
    // Per slot compare enable from APB block
    input  wire csrVecT csrCmpEn_i,
    // RVFI CSR views, one word per slot
    input  wire csrBusT csrRdata_i,
    input  wire csrBusT csrWdata_i,
    input  wire csrBusT csrWmask_i,
    // Trace side
    output      csrBusT csrValue_o,
    output      csrVecT csrWb_o
);

    csrBusT merged;
    csrBusT heldQ;
    csrVecT changed;

    //////////////////////////////////////////////////
    // Merge and compare
    //////////////////////////////////////////////////

    // Written bits under mask, read bits elsewhere
    always_comb begin
        for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
            merged[i] = (csrWdata_i[i] & csrWmask_i[i])
                      | (csrRdata_i[i] & ~csrWmask_i[i]);
        end
    end

    // Difference against last held value
    always_comb begin
        for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
            changed[i] = (merged[i] != heldQ[i]);
        end
    end

    //////////////////////////////////////////////////
    // Held values and flags
    //////////////////////////////////////////////////

    // Held copy starts at zero, moves only on retirement
    always_ff @(posedge rvvi_i or negedge rstN_i) begin
        if (!rstN_i) begin
            heldQ <= '0;
        end else if (retire_i) begin
            heldQ <= merged;
        end
    end

    // Flags live for one trace cycle
    always_ff @(posedge rvvi_i or negedge rstN_i) begin
        if (!rstN_i) begin
            csrWb_o <= '0;
        end else if (retire_i) begin
            // Compare off hides the slot
            csrWb_o <= changed & csrCmpEn_i;
        end else begin
            csrWb_o <= '0;
        end
    end

    assign csrValue_o = heldQ;

endmodule

`default_nettype wire

// File: rtl/rvviNetEvents.sv
// Irq and halt request change detection, pending event set and valid/ready output
`default_nettype none

`include "rvviBridge_settings.svh"

module rvviNetEvents import rvviBridgePkg::*; (
    input  wire logic   rvvi_i,
    input  wire logic   rstN_i,
    input  wire logic   enable_i,
    input  wire irqVecT irqMask_i,
    // Watched nets
    input  wire irqVecT irq_i,
    input  wire logic   debugReq_i,
    // Event output
    input  wire logic   netReady_i,
    output      logic   netValid_o,
    output      netIdxT netIdx_o,
    output      logic   netValue_o
);

    logic [`RVVI_NUM_NETS-1:0] netLvl;
    logic [`RVVI_NUM_NETS-1:0] prevLvlQ;
    logic [`RVVI_NUM_NETS-1:0] watch;
    logic [`RVVI_NUM_NETS-1:0] newEvt;
    logic [`RVVI_NUM_NETS-1:0] clrEvt;
    logic [`RVVI_NUM_NETS-1:0] pendingQ;
    netIdxT                    lowIdx;
    netIdxT                    idxQ;
    netStateT                  stateQ;
    logic                      accept;

    //////////////////////////////////////////////////
    // Change detection
    //////////////////////////////////////////////////

    // Halt request on top of the irq lines
    assign netLvl = {debugReq_i, irq_i};

    // Halt request is always watched
    assign watch = {1'b1, irqMask_i};

    // Watched level changes only while enabled
    assign newEvt = enable_i ? ((netLvl ^ prevLvlQ) & watch) : '0;

    // Previous levels follow the nets whether enabled or not
    always_ff @(posedge rvvi_i or negedge rstN_i) begin
        if (!rstN_i) begin
            prevLvlQ <= '0;
        end else begin
            prevLvlQ <= netLvl;
        end
    end

    //////////////////////////////////////////////////
    // Pending set
    //////////////////////////////////////////////////

    // Handshake on the offered index
    assign accept = (stateQ == netOffer) & netReady_i;

    // Offered bit drops on handshake
    always_comb begin
        clrEvt = '0;
        if (accept) begin
            clrEvt[idxQ] = 1'b1;
        end
    end

    // Repeat change of a pending net merges into one event
    always_ff @(posedge rvvi_i or negedge rstN_i) begin
        if (!rstN_i) begin
            pendingQ <= '0;
        end else begin
            pendingQ <= (pendingQ & ~clrEvt) | newEvt;
        end
    end

    // Lowest pending index wins
    always_comb begin
        lowIdx = '0;
        for (int i = `RVVI_NUM_NETS-1; i >= 0; i--) begin
            if (pendingQ[i]) begin
                lowIdx = netIdxT'(i);
            end
        end
    end

    //////////////////////////////////////////////////
    // Output FSM
    //////////////////////////////////////////////////
    always_ff @(posedge rvvi_i or negedge rstN_i) begin
        if (!rstN_i) begin
            stateQ <= netIdle;
            idxQ   <= '0;
        end else begin
            case (stateQ)
                netIdle: begin
                    // Pick up the lowest pending net
                    if (pendingQ != '0) begin
                        stateQ <= netOffer;
                        idxQ   <= lowIdx;
                    end
                end
                netOffer: begin
                    // Index held until accepted
                    if (netReady_i) begin
                        stateQ <= netIdle;
                    end
                end
            endcase
        end
    end

    assign netValid_o = (stateQ == netOffer);
    assign netIdx_o   = idxQ;

    // Live level of the offered net
    assign netValue_o = netLvl[idxQ];

endmodule

`default_nettype wire

// File: rtl/rvviBridgeTop.sv
// Trace bridge top level: APB registers, retirement stage, CSR merge and net events
`default_nettype none

`include "rvviBridge_settings.svh"

module rvviBridgeTop import rvviBridgePkg::*; (
    input  wire logic                     rvvi_i,
    input  wire logic                     rstN_i,
    // APB slave
    input  wire logic [`RVVI_APB_AW-1:0]  paddr_i,
    input  wire logic                     psel_i,
    input  wire logic                     penable_i,
    input  wire logic                     pwrite_i,
    input  wire xlenT                     pwdata_i,
    output      xlenT                     prdata_o,
    output      logic                     pready_o,
    // RVFI retirement port
    input  wire logic                     rvfiValid_i,
    input  wire logic [`RVVI_ORDER_W-1:0] rvfiOrder_i,
    input  wire xlenT                     rvfiInsn_i,
    input  wire xlenT                     rvfiPc_i,
    input  wire logic                     rvfiTrap_i,
    input  wire logic                     rvfiIntr_i,
    input  wire logic [`RVVI_MODE_W-1:0]  rvfiMode_i,
    input  wire logic [`RVVI_IXL_W-1:0]   rvfiIxl_i,
    input  wire gprAddrT                  rdAddr0_i,
    input  wire gprAddrT                  rdAddr1_i,
    input  wire xlenT                     rdWdata0_i,
    input  wire xlenT                     rdWdata1_i,
    // RVFI CSR views
    input  wire csrBusT                   csrRdata_i,
    input  wire csrBusT                   csrWdata_i,
    input  wire csrBusT                   csrWmask_i,
    // Watched nets
    input  wire irqVecT                   irq_i,
    input  wire logic                     debugReq_i,
    input  wire logic                     netReady_i,
    output      logic                     netValid_o,
    output      netIdxT                   netIdx_o,
    output      logic                     netValue_o,
    // RVVI trace side
    output      logic                     valid_o,
    output      logic [`RVVI_ORDER_W-1:0] order_o,
    output      xlenT                     insn_o,
    output      xlenT                     pc_o,
    output      logic                     trap_o,
    output      logic                     intr_o,
    output      logic [`RVVI_MODE_W-1:0]  mode_o,
    output      logic [`RVVI_IXL_W-1:0]   ixl_o,
    output      gprVecT                   xWb_o,
    output      xlenT                     xWdata0_o,
    output      xlenT                     xWdata1_o,
    output      csrBusT                   csrValue_o,
    output      csrVecT                   csrWb_o
);

    logic   enable;
    logic   retireFire;
    csrVecT csrCmpEn;
    irqVecT irqMask;

    rvviApbRegs uRegs (
        .rvvi_i       (rvvi_i),
        .rstN_i       (rstN_i),
        .paddr_i      (paddr_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .retireFire_i (retireFire),
        .enable_o     (enable),
        .csrCmpEn_o   (csrCmpEn),
        .irqMask_o    (irqMask)
    );

    rvviRetireStage uRetire (
        .rvvi_i       (rvvi_i),
        .rstN_i       (rstN_i),
        .enable_i     (enable),
        .rvfiValid_i  (rvfiValid_i),
        .rvfiOrder_i  (rvfiOrder_i),
        .rvfiInsn_i   (rvfiInsn_i),
        .rvfiPc_i     (rvfiPc_i),
        .rvfiTrap_i   (rvfiTrap_i),
        .rvfiIntr_i   (rvfiIntr_i),
        .rvfiMode_i   (rvfiMode_i),
        .rvfiIxl_i    (rvfiIxl_i),
        .rdAddr0_i    (rdAddr0_i),
        .rdAddr1_i    (rdAddr1_i),
        .rdWdata0_i   (rdWdata0_i),
        .rdWdata1_i   (rdWdata1_i),
        .retireFire_o (retireFire),
        .valid_o      (valid_o),
        .order_o      (order_o),
        .insn_o       (insn_o),
        .pc_o         (pc_o),
        .trap_o       (trap_o),
        .intr_o       (intr_o),
        .mode_o       (mode_o),
        .ixl_o        (ixl_o),
        .xWb_o        (xWb_o),
        .xWdata0_o    (xWdata0_o),
        .xWdata1_o    (xWdata1_o)
    );

    rvviCsrMerge uCsr (
        .rvvi_i     (rvvi_i),
        .rstN_i     (rstN_i),
        .retire_i   (retireFire),
        .csrCmpEn_i (csrCmpEn),
        .csrRdata_i (csrRdata_i),
        .csrWdata_i (csrWdata_i),
        .csrWmask_i (csrWmask_i),
        .csrValue_o (csrValue_o),
        .csrWb_o    (csrWb_o)
    );

    rvviNetEvents uNets (
        .rvvi_i     (rvvi_i),
        .rstN_i     (rstN_i),
        .enable_i   (enable),
        .irqMask_i  (irqMask),
        .irq_i      (irq_i),
        .debugReq_i (debugReq_i),
        .netReady_i (netReady_i),
        .netValid_o (netValid_o),
        .netIdx_o   (netIdx_o),
        .netValue_o (netValue_o)
    );

endmodule

`default_nettype wire

// File: dv/tbClock.sv
// Testbench clock and reset generator, 8 ns period, reset held low for five cycles
`default_nettype none

module tbClock (
    output logic clk_o,
    output logic rstN_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // Free running 125 MHz clock
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // Reset released on the fifth rising edge
    initial begin
        rstN_o = 1'b0;
        repeat (5) @(posedge clk_o);
        rstN_o <= 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/rvviBridgeTb.sv
// Trace bridge testbench: stimulus table, APB tasks, retirement monitor, net checks, watchdog
`default_nettype none

`include "rvviBridge_settings.svh"

module rvviBridgeTb
    import rvviBridgePkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // One table row, either a retirement or a net toggle
    typedef struct packed {
        logic        isNet;
        logic        b2b;
        gprAddrT     rd0;
        gprAddrT     rd1;
        logic        sameCsr;
        csrVecT      cmpEn;
        logic [32:0] toggle;
        int          stall;
    } stepT;

    // What the trace side must show one cycle after a retirement
    typedef struct packed {
        logic [63:0] order;
        xlenT        insn;
        xlenT        pc;
        logic        trap;
        logic        intr;
        logic [1:0]  mode;
        logic [1:0]  ixl;
        gprVecT      xWb;
        xlenT        wd0;
        xlenT        wd1;
        csrBusT      csr;
        csrVecT      csrWb;
    } retireExpT;

    localparam int NUM_STEPS   = 12;
    localparam int TIMEOUT_CYC = NUM_STEPS * 20 + 200;

    // net, b2b, rd0, rd1, sameCsr, cmpEn, toggle, stall
    stepT steps [NUM_STEPS] = '{
        '{1'b0, 1'b0, 5'd1,  5'd2,  1'b0, 8'hFF, 33'h0, 0},
        '{1'b0, 1'b1, 5'd0,  5'd7,  1'b0, 8'hFF, 33'h0, 0},
        '{1'b0, 1'b1, 5'd9,  5'd9,  1'b1, 8'hFF, 33'h0, 0},
        '{1'b0, 1'b1, 5'd0,  5'd0,  1'b0, 8'hFF, 33'h0, 0},
        '{1'b0, 1'b0, 5'd31, 5'd4,  1'b0, 8'hF7, 33'h0, 0},
        '{1'b0, 1'b1, 5'd12, 5'd0,  1'b0, 8'hF7, 33'h0, 0},
        '{1'b0, 1'b0, 5'd3,  5'd3,  1'b0, 8'hFF, 33'h0, 0},
        '{1'b1, 1'b0, 5'd0,  5'd0,  1'b0, 8'hFF, 33'h0_0000_0088, 0},
        '{1'b1, 1'b0, 5'd0,  5'd0,  1'b0, 8'hFF, 33'h1_0001_0000, 2},
        '{1'b1, 1'b0, 5'd0,  5'd0,  1'b0, 8'hFF, 33'h0_0000_0001, 0},
        '{1'b1, 1'b0, 5'd0,  5'd0,  1'b0, 8'hFF, 33'h0_8000_0809, 3},
        '{1'b0, 1'b0, 5'd20, 5'd21, 1'b0, 8'hFF, 33'h0, 0}
    };

    // DUT side signals, named after the top level ports
    logic rvvi_i, rstN_i;
    logic [`RVVI_APB_AW-1:0] paddr_i;
    logic psel_i, penable_i, pwrite_i, pready_o;
    xlenT pwdata_i, prdata_o;
    logic rvfiValid_i, rvfiTrap_i, rvfiIntr_i;
    logic [63:0] rvfiOrder_i, order_o;
    xlenT rvfiInsn_i, rvfiPc_i, rdWdata0_i, rdWdata1_i;
    logic [1:0] rvfiMode_i, rvfiIxl_i, mode_o, ixl_o;
    gprAddrT rdAddr0_i, rdAddr1_i;
    csrBusT csrRdata_i, csrWdata_i, csrWmask_i, csrValue_o;
    irqVecT irq_i;
    logic debugReq_i, netReady_i, netValid_o, netValue_o;
    netIdxT netIdx_o;
    logic valid_o, trap_o, intr_o;
    xlenT insn_o, pc_o, xWdata0_o, xWdata1_o;
    gprVecT xWb_o;
    csrVecT csrWb_o;

    // Reference state kept by the testbench
    retireExpT   expQ [$];
    retireExpT   monExp;
    csrBusT      csrR, csrW, csrM, csrHeld;
    csrVecT      cmpEnModel = `RVVI_CSRCMP_RST;
    irqVecT      irqMaskModel = `RVVI_IRQMASK_RST;
    logic [32:0] netLvl = '0;
    logic        enableModel = 1'b0;
    int          retCount = 0;
    int          errCount = 0;
    int          checkCount = 0;
    int          monSlot;

    tbClock clkGen (.clk_o(rvvi_i), .rstN_o(rstN_i));

    rvviBridgeTop UUT (.*);

    task automatic checkVal(input string name, input logic [63:0] got, input logic [63:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("FAIL %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // APB transfers, setup then one access phase
    //////////////////////////////////////////////////
    task automatic apbWrite(input logic [3:0] addr, input xlenT data);
        @(posedge rvvi_i);
        paddr_i   <= addr;
        pwdata_i  <= data;
        pwrite_i  <= 1'b1;
        psel_i    <= 1'b1;
        @(posedge rvvi_i);
        penable_i <= 1'b1;
        // Register updates on this edge
        @(posedge rvvi_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic apbReadCheck(input logic [3:0] addr, input xlenT exp, input string name);
        @(posedge rvvi_i);
        paddr_i   <= addr;
        pwrite_i  <= 1'b0;
        psel_i    <= 1'b1;
        @(posedge rvvi_i);
        penable_i <= 1'b1;
        // Mid access phase
        @(negedge rvvi_i);
        checkVal("pready_o", pready_o, 1'b1);
        checkVal(name, prdata_o, exp);
        @(posedge rvvi_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic idleRetire();
        @(posedge rvvi_i);
        rvfiValid_i <= 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Retirement driver with expected values
    //////////////////////////////////////////////////
    task automatic driveRetire(input stepT st);
        retireExpT e;
        xlenT      d0;
        xlenT      d1;
        xlenT      merged;
        int        s;
        if (st.cmpEn != cmpEnModel) begin
            idleRetire();
            apbWrite(`RVVI_REG_CSRCMP, xlenT'(st.cmpEn));
            cmpEnModel = st.cmpEn;
        end else if (!st.b2b) begin
            idleRetire();
        end
        // Fresh CSR views unless the row repeats the last ones
        if (!st.sameCsr) begin
            for (s = 0; s < `RVVI_NUM_CSR; s++) begin
                csrR[s] = $urandom;
                csrW[s] = $urandom;
                csrM[s] = $urandom;
            end
        end
        e.order = {$urandom, $urandom};
        e.insn  = $urandom;
        e.pc    = $urandom;
        e.trap  = 1'($urandom);
        e.intr  = 1'($urandom);
        e.mode  = 2'($urandom);
        e.ixl   = 2'($urandom);
        d0      = $urandom;
        d1      = $urandom;
        // x0 never flagged
        e.xWb = '0;
        if (st.rd0 != '0) e.xWb[st.rd0] = 1'b1;
        if (st.rd1 != '0) e.xWb[st.rd1] = 1'b1;
        e.wd0 = (st.rd0 == st.rd1) ? d1 : d0;
        e.wd1 = d1;
        @(posedge rvvi_i);
        rvfiValid_i <= 1'b1;
        rvfiOrder_i <= e.order;
        rvfiInsn_i  <= e.insn;
        rvfiPc_i    <= e.pc;
        rvfiTrap_i  <= e.trap;
        rvfiIntr_i  <= e.intr;
        rvfiMode_i  <= e.mode;
        rvfiIxl_i   <= e.ixl;
        rdAddr0_i   <= st.rd0;
        rdAddr1_i   <= st.rd1;
        rdWdata0_i  <= d0;
        rdWdata1_i  <= d1;
        csrRdata_i  <= csrR;
        csrWdata_i  <= csrW;
        csrWmask_i  <= csrM;
        if (enableModel) begin
            // Written bits under mask, read bits elsewhere
            for (s = 0; s < `RVVI_NUM_CSR; s++) begin
                merged     = (csrW[s] & csrM[s]) | (csrR[s] & ~csrM[s]);
                e.csrWb[s] = (merged != csrHeld[s]) && cmpEnModel[s];
                csrHeld[s] = merged;
            end
            e.csr = csrHeld;
            expQ.push_back(e);
            retCount++;
        end
    endtask

    //////////////////////////////////////////////////
    // Net toggles and event handshake
    //////////////////////////////////////////////////
    task automatic runNet(input stepT st);
        int n;
        int k;
        int waitCnt;
        bit first;
        idleRetire();
        netLvl     = netLvl ^ st.toggle;
        irq_i      <= netLvl[31:0];
        debugReq_i <= netLvl[32];
        first = 1'b1;
        for (n = 0; n < `RVVI_NUM_NETS; n++) begin
            // Halt request always watched, irq lines by mask
            if (st.toggle[n] && (n == `RVVI_NET_HALT || irqMaskModel[n])) begin
                waitCnt = 0;
                @(negedge rvvi_i);
                while (!netValid_o && waitCnt < 20) begin
                    @(negedge rvvi_i);
                    waitCnt++;
                end
                if (!netValid_o) begin
                    errCount++;
                    $display("No net event offered for net %0d by %0t", n, $time);
                end else begin
                    checkVal("netIdx_o", netIdx_o, n);
                    checkVal("netValue_o", netValue_o, netLvl[n]);
                    // Back-pressure hold
                    for (k = 0; k < (first ? st.stall : 0); k++) begin
                        @(negedge rvvi_i);
                        checkVal("netValid_o", netValid_o, 1'b1);
                        checkVal("netIdx_o", netIdx_o, n);
                    end
                    first = 1'b0;
                    @(posedge rvvi_i);
                    netReady_i <= 1'b1;
                    @(posedge rvvi_i);
                    netReady_i <= 1'b0;
                end
            end
        end
        // Queue must be empty now
        repeat (4) begin
            @(negedge rvvi_i);
            checkVal("netValid_o", netValid_o, 1'b0);
        end
    endtask

    // Trace side monitor, one expected entry per valid_o
    always @(negedge rvvi_i) begin
        if (rstN_i) begin
            if (valid_o && expQ.size() == 0) begin
                errCount++;
                $display("Unexpected retirement on valid_o at %0t", $time);
            end else if (valid_o) begin
                monExp = expQ.pop_front();
                checkVal("order_o", order_o, monExp.order);
                checkVal("insn_o", insn_o, monExp.insn);
                checkVal("pc_o", pc_o, monExp.pc);
                checkVal("trap_o", trap_o, monExp.trap);
                checkVal("intr_o", intr_o, monExp.intr);
                checkVal("mode_o", mode_o, monExp.mode);
                checkVal("ixl_o", ixl_o, monExp.ixl);
                checkVal("xWb_o", xWb_o, monExp.xWb);
                checkVal("xWdata0_o", xWdata0_o, monExp.wd0);
                checkVal("xWdata1_o", xWdata1_o, monExp.wd1);
                for (monSlot = 0; monSlot < `RVVI_NUM_CSR; monSlot++) begin
                    checkVal($sformatf("csrValue_o[%0d]", monSlot), csrValue_o[monSlot],
                             monExp.csr[monSlot]);
                end
                checkVal("csrWb_o", csrWb_o, monExp.csrWb);
            end else begin
                checkVal("xWb_o", xWb_o, '0);
                checkVal("csrWb_o", csrWb_o, '0);
            end
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        int seedVal;
        int i;
        int waitCnt;
        seedVal = $urandom(98);
        paddr_i = '0;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        pwdata_i = '0;
        rvfiValid_i = 1'b0;
        rvfiOrder_i = '0;
        rvfiInsn_i = '0;
        rvfiPc_i = '0;
        rvfiTrap_i = 1'b0;
        rvfiIntr_i = 1'b0;
        rvfiMode_i = '0;
        rvfiIxl_i = '0;
        rdAddr0_i = '0;
        rdAddr1_i = '0;
        rdWdata0_i = '0;
        rdWdata1_i = '0;
        csrRdata_i = '0;
        csrWdata_i = '0;
        csrWmask_i = '0;
        csrHeld = '0;
        irq_i = '0;
        debugReq_i = 1'b0;
        netReady_i = 1'b0;
        @(posedge rstN_i);

        // Register map after reset
        apbReadCheck(`RVVI_REG_CTRL, 32'h0, "CTRL");
        apbReadCheck(`RVVI_REG_CSRCMP, 32'hFF, "CSRCMP");
        apbReadCheck(`RVVI_REG_IRQMASK, `RVVI_IRQMASK_RST, "IRQMASK");
        apbReadCheck(`RVVI_REG_RETCNT, 32'h0, "RETCNT");
        apbReadCheck(4'h2, 32'h0, "unmapped offset 0x2");
        apbWrite(`RVVI_REG_CSRCMP, 32'h5A);
        apbReadCheck(`RVVI_REG_CSRCMP, 32'h5A, "CSRCMP");
        apbWrite(`RVVI_REG_IRQMASK, 32'h1234_5678);
        apbReadCheck(`RVVI_REG_IRQMASK, 32'h1234_5678, "IRQMASK");
        // Counter is read only
        apbWrite(`RVVI_REG_RETCNT, 32'hDEAD);
        apbReadCheck(`RVVI_REG_RETCNT, 32'h0, "RETCNT");
        apbWrite(`RVVI_REG_CSRCMP, 32'hFF);
        apbWrite(`RVVI_REG_IRQMASK, `RVVI_IRQMASK_RST);

        // Bridge off, monitor flags any valid_o
        driveRetire(steps[0]);
        idleRetire();
        repeat (3) @(negedge rvvi_i);
        apbWrite(`RVVI_REG_CTRL, 32'h1);
        enableModel = 1'b1;
        apbReadCheck(`RVVI_REG_CTRL, 32'h1, "CTRL");

        for (i = 0; i < NUM_STEPS; i++) begin
            if (steps[i].isNet) begin
                runNet(steps[i]);
            end else begin
                driveRetire(steps[i]);
            end
        end
        idleRetire();

        // Drain the trace side
        waitCnt = 0;
        while (expQ.size() != 0 && waitCnt < 20) begin
            @(negedge rvvi_i);
            waitCnt++;
        end
        if (expQ.size() != 0) begin
            errCount++;
            $display("%0d retirements never appeared on valid_o", expQ.size());
        end
        apbReadCheck(`RVVI_REG_RETCNT, xlenT'(retCount), "RETCNT");

        $display("Checks run %0d, errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #(TIMEOUT_CYC * 8);
        $display("Timeout after %0d cycles, the run did not complete", TIMEOUT_CYC);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: rvviBridge.f
+incdir+include
rtl/rvviBridgePkg.sv
rtl/rvviApbRegs.sv
rtl/rvviRetireStage.sv
rtl/rvviCsrMerge.sv
rtl/rvviNetEvents.sv
rtl/rvviBridgeTop.sv
dv/tbClock.sv
dv/rvviBridgeTb.sv
